// File: common/fdc_settings.svh
/*
 * floppy subsystem build constants:
 * sector size, block count, credit depth, I/O base
 */
`ifndef FDC_SETTINGS_SVH
`define FDC_SETTINGS_SVH

// bytes per sector, kept small for short runs
`define FDC_SECTOR_BYTES 16

// blocks held by the store
`define FDC_BLOCKS 16

// staging depth per direction, also the credit count (power of two)
`define FDC_CREDITS 4

// start of the 16-address controller window
`define FDC_IO_BASE 20'h3F0

`endif

// File: common/fdc_pkg.sv
/*
 * floppy subsystem types:
 * data, block, count and credit widths,
 * result codes, opcodes, engine and store states
 */
`include "fdc_settings.svh"

package fdc_pkg;

   typedef logic [7:0] fdc_byte_t;   // data byte
   typedef logic [7:0] fdc_block_t;  // block number from command byte
   typedef logic [$clog2(`FDC_SECTOR_BYTES + 1)-1:0] fdc_count_t; // 0..sector size
   typedef logic [$clog2(`FDC_CREDITS + 1)-1:0] fdc_credit_t;     // 0..credit depth
   typedef logic [7:0] fdc_status_t; // result byte

   localparam fdc_status_t STAT_OK  = 8'h00; // done
   localparam fdc_status_t STAT_TC  = 8'h40; // cut short by tc
   localparam fdc_status_t STAT_BAD = 8'h80; // bad opcode or dma off

   localparam fdc_byte_t OP_WRITE = 8'h05; // write sector
   localparam fdc_byte_t OP_READ  = 8'h06; // read sector

   // engine FSM
   typedef enum logic [2:0] {E_IDLE, E_ISSUE, E_XFER, E_DRAIN, E_DONE} eng_state_t;

   // block store FSM
   typedef enum logic [1:0] {S_IDLE, S_RD, S_WR} store_state_t;

endpackage

// File: common/sector_if.sv
/*
 * engine to block store link:
 * block request, write bytes, read bytes,
 * credit returns both ways
 */
`timescale 1ns/10ps

interface sector_if import fdc_pkg::*; ();

   logic        req_valid; // block request pending
   logic        req_write; // 1 = write sector
   fdc_block_t  req_block; // block to access
   logic        req_ready; // store can take a request
   logic        wr_valid;  // write byte, spends one credit
   fdc_byte_t   wr_data;   // write byte value
   logic        wr_credit; // store committed one byte
   logic        rd_valid;  // read byte, spends one credit
   fdc_byte_t   rd_data;   // read byte value
   logic        rd_credit; // engine freed one buffer slot

   modport engine (
      output req_valid, req_write, req_block, wr_valid, wr_data, rd_credit,
      input  req_ready, wr_credit, rd_valid, rd_data
   );

   modport store (
      input  req_valid, req_write, req_block, wr_valid, wr_data, rd_credit,
      output req_ready, wr_credit, rd_valid, rd_data
   );

endinterface

// File: floppy/fdc_regs.sv
/*
 * floppy host registers:
 * I/O window decode, DOR, MSR, two-byte command
 * capture, result byte and irq6
 */
`timescale 1ns/10ps
`include "fdc_settings.svh"

module fdc_regs import fdc_pkg::*; (
   input  logic        clk,        // system clock
   input  logic        rst,        // sync reset
   input  logic [19:0] a,          // host address
   input  fdc_byte_t   d_in,       // host write data
   input  logic        ior_n,      // io read strobe
   input  logic        iow_n,      // io write strobe
   input  logic        dack2,      // dma cycle, masks io decode
   input  logic        cmd_busy,   // engine running
   input  logic        cmd_done,   // engine finished, one clock
   input  fdc_status_t cmd_status, // engine result
   output fdc_byte_t   reg_d_out,  // read data, zero when idle
   output logic        reg_d_oe,   // register read in progress
   output logic        irq6,       // interrupt to host
   output logic        cmd_start,  // launch pulse
   output logic        cmd_write,  // 1 = write sector
   output fdc_block_t  cmd_block,  // block for the engine
   output logic        dma_en      // DOR bit 3
);

   localparam logic [19:0] IO_BASE = `FDC_IO_BASE;

   logic        in_range; // a inside the window
   logic        io_rd;    // host register read
   logic        io_wr;    // host register write
   logic [3:0]  offs;     // register offset
   fdc_byte_t   dor;      // digital output register
   fdc_byte_t   opcode;   // first command byte
   logic        have_op;  // opcode in, block byte next
   logic        res_pend; // result not yet read
   fdc_status_t result;   // result byte
   logic        rqm;      // ready for a command byte
   logic        cmd_ok;   // opcode known and dma on
   fdc_byte_t   msr;      // main status

   assign in_range = (a[19:4] == IO_BASE[19:4]);
   assign io_rd    = ~ior_n & ~dack2 & in_range;
   assign io_wr    = ~iow_n & ~dack2 & in_range;
   assign offs     = a[3:0];
   assign dma_en   = dor[3];
   assign rqm      = ~cmd_busy & ~cmd_start & ~res_pend;
   assign cmd_ok   = ((opcode == OP_READ) | (opcode == OP_WRITE)) & dma_en;
   assign msr      = {rqm, 2'b00, cmd_busy | cmd_start, 4'b0000}; // bit7 rqm, bit4 busy

   // read mux, no register between bus and data
   always_comb begin
      reg_d_out = '0;
      if (io_rd) begin
         case (offs)
            4'h2:    reg_d_out = dor;
            4'h4:    reg_d_out = msr;
            4'h5:    reg_d_out = result;
            default: reg_d_out = '0;
         endcase
      end
   end

   assign reg_d_oe = io_rd;

   always_ff @(posedge clk) begin
      if (rst) begin
         dor       <= '0;
         have_op   <= 1'b0;
         res_pend  <= 1'b0;
         irq6      <= 1'b0;
         cmd_start <= 1'b0;
         result    <= STAT_OK;
      end else begin
         cmd_start <= 1'b0; // single clock
         if (io_wr && offs == 4'h2) begin
            dor <= d_in;
         end
         if (io_wr && offs == 4'h5 && rqm) begin
            have_op <= ~have_op;
            if (have_op && cmd_ok) begin
               cmd_start <= 1'b1;
            end else if (have_op) begin
               result   <= STAT_BAD; // rejected before the engine
               res_pend <= 1'b1;
               irq6     <= 1'b1;
            end
         end
         if (cmd_done) begin
            result   <= cmd_status;
            res_pend <= 1'b1;
            irq6     <= 1'b1; // one clock after done
         end
         if (io_rd && offs == 4'h5 && res_pend) begin
            res_pend <= 1'b0;
            irq6     <= 1'b0;
         end
      end
   end

   // command bytes
   always_ff @(posedge clk) begin
      if (io_wr && offs == 4'h5 && rqm) begin
         if (!have_op) begin
            opcode <= d_in;
         end else begin
            cmd_block <= d_in;
            cmd_write <= (opcode == OP_WRITE);
         end
      end
   end

endmodule

// File: floppy/sector_engine.sv
/*
 * sector transfer engine:
 * block request, DMA byte handshake on channel 2,
 * read buffer, credit accounting, tc abort
 */
`timescale 1ns/10ps
`include "fdc_settings.svh"

module sector_engine import fdc_pkg::*; (
   input  logic        clk,        // system clock
   input  logic        rst,        // sync reset
   input  logic        cmd_start,  // launch pulse
   input  logic        cmd_write,  // 1 = write sector
   input  fdc_block_t  cmd_block,  // block to access
   input  logic        dma_en,     // DOR dma gate
   input  logic        dack2,      // dma acknowledge
   input  logic        tc,         // terminal count
   input  logic        ior_n,      // dma read strobe
   input  logic        iow_n,      // dma write strobe
   input  fdc_byte_t   d_in,       // dma write data
   output logic        cmd_busy,   // command running
   output logic        cmd_done,   // one clock at end
   output fdc_status_t cmd_status, // result for the regs
   output logic        drq2,       // dma request
   output fdc_byte_t   dma_d_out,  // dma read data, zero when idle
   output logic        dma_d_oe,   // dma read in progress
   sector_if.engine    sif         // link to block store
);

   localparam fdc_count_t  SECT = fdc_count_t'(`FDC_SECTOR_BYTES);
   localparam fdc_count_t  LAST = fdc_count_t'(`FDC_SECTOR_BYTES - 1);
   localparam fdc_credit_t CRED = fdc_credit_t'(`FDC_CREDITS);
   localparam int          PW   = $clog2(`FDC_CREDITS); // buffer pointer width

   eng_state_t    state;
   logic          wr_mode;             // current command writes
   fdc_block_t    blk;                 // latched block
   logic          aborted;             // tc came early
   fdc_count_t    xfer_cnt;            // dma bytes moved
   fdc_count_t    rx_cnt;              // bytes received from store
   fdc_credit_t   wr_cred;             // write credits held
   fdc_byte_t     rbuf [`FDC_CREDITS]; // read buffer
   logic [PW-1:0] rbuf_wp;
   logic [PW-1:0] rbuf_rp;
   fdc_credit_t   rbuf_fill;
   logic          dma_byte;            // strobe with dack2
   logic          take;                // byte accepted this clock
   logic          wr_take;
   logic          rd_pop;              // buffer slot freed
   logic          drain_done;

   assign dma_byte = dack2 & (wr_mode ? ~iow_n : ~ior_n);
   assign take     = dma_byte & drq2;
   assign wr_take  = take & wr_mode;
   assign drq2     = (state == E_XFER) & dma_en &
                     (wr_mode ? (wr_cred != '0) : (rbuf_fill != '0));
   assign rd_pop   = ~wr_mode & (take | ((state == E_DRAIN) & (rbuf_fill != '0)));

   // write: all credits back; read: store paid up and buffer flushed
   assign drain_done = wr_mode ? (wr_cred == CRED) : ((rx_cnt == SECT) & (rbuf_fill == '0));

   assign cmd_busy      = (state != E_IDLE);
   assign cmd_done      = (state == E_DONE);
   assign cmd_status    = aborted ? STAT_TC : STAT_OK;
   assign dma_d_oe      = dack2 & ~ior_n & ~wr_mode & (state == E_XFER);
   assign dma_d_out     = dma_d_oe ? rbuf[rbuf_rp] : '0;
   assign sif.req_valid = (state == E_ISSUE);
   assign sif.req_write = wr_mode;
   assign sif.req_block = blk;

   always_ff @(posedge clk) begin
      if (rst) begin
         state         <= E_IDLE;
         wr_mode       <= 1'b0;
         aborted       <= 1'b0;
         xfer_cnt      <= '0;
         rx_cnt        <= '0;
         wr_cred       <= CRED;
         rbuf_wp       <= '0;
         rbuf_rp       <= '0;
         rbuf_fill     <= '0;
         sif.wr_valid  <= 1'b0;
         sif.rd_credit <= 1'b0;
      end else begin
         case (state)
            E_IDLE: if (cmd_start) begin
               state    <= E_ISSUE;
               wr_mode  <= cmd_write;
               aborted  <= 1'b0;
               xfer_cnt <= '0;
               rx_cnt   <= '0;
            end
            E_ISSUE: if (sif.req_ready) state <= E_XFER;
            E_XFER: if (take) begin
               xfer_cnt <= xfer_cnt + 1'b1;
               if (xfer_cnt == LAST) begin
                  state <= E_DRAIN;
               end else if (tc) begin
                  aborted <= 1'b1; // early tc
                  state   <= E_DRAIN;
               end
            end
            E_DRAIN: if (drain_done) state <= E_DONE;
            E_DONE:  state <= E_IDLE;
            default: state <= E_IDLE;
         endcase
         if (sif.rd_valid) rx_cnt <= rx_cnt + 1'b1;
         sif.wr_valid  <= wr_take;
         sif.rd_credit <= rd_pop; // one credit per slot freed
         wr_cred   <= wr_cred - fdc_credit_t'(wr_take) + fdc_credit_t'(sif.wr_credit);
         if (sif.rd_valid) rbuf_wp <= rbuf_wp + 1'b1;
         if (rd_pop) rbuf_rp <= rbuf_rp + 1'b1;
         rbuf_fill <= rbuf_fill + fdc_credit_t'(sif.rd_valid) - fdc_credit_t'(rd_pop);
      end
   end

   always_ff @(posedge clk) begin
      if (state == E_IDLE && cmd_start) blk <= cmd_block;
      if (wr_take) sif.wr_data <= d_in;
      if (sif.rd_valid) rbuf[rbuf_wp] <= sif.rd_data;
   end

endmodule

// File: sdcard/sd_block_store.sv
/*
 * sd card stand-in:
 * block RAM behind a write staging FIFO,
 * read streaming under credit
 */
`timescale 1ns/10ps
`include "fdc_settings.svh"

module sd_block_store import fdc_pkg::*; (
   input  logic     clk, // system clock
   input  logic     rst, // sync reset
   sector_if.store  sif  // link to engine
);

   localparam int          DEPTH    = `FDC_BLOCKS * `FDC_SECTOR_BYTES;
   localparam int          AW       = $clog2(DEPTH);
   localparam int          IW       = $clog2(`FDC_SECTOR_BYTES); // byte index width
   localparam int          PW       = $clog2(`FDC_CREDITS);
   localparam logic [IW-1:0] LAST_IDX = IW'(`FDC_SECTOR_BYTES - 1);
   localparam fdc_credit_t CRED     = fdc_credit_t'(`FDC_CREDITS);

   store_state_t   state;
   fdc_byte_t      mem [DEPTH];           // block RAM
   fdc_byte_t      stage [`FDC_CREDITS];  // write staging FIFO
   logic [PW-1:0]  st_wp;
   logic [PW-1:0]  st_rp;
   fdc_credit_t    st_fill;
   logic [AW-IW-1:0] blk;                 // block, low bits only
   logic [IW-1:0]  idx;                   // byte within block
   fdc_credit_t    rd_cred;               // read credits held
   logic           commit;                // FIFO head into RAM
   logic           send;                  // RAM byte out
   logic           accept;                // request taken
   logic [AW-1:0]  addr;

   assign addr   = {blk, idx}; // sizes are powers of two
   assign commit = (state == S_WR) & (st_fill != '0);
   assign send   = (state == S_RD) & (rd_cred != '0);
   // after an abort WR never finishes, so take the next request once drained
   assign sif.req_ready = (state == S_IDLE) |
                          ((state == S_WR) & (st_fill == '0) & ~sif.wr_valid);
   assign accept = sif.req_valid & sif.req_ready;

   always_ff @(posedge clk) begin
      if (rst) begin
         state         <= S_IDLE;
         idx           <= '0;
         st_wp         <= '0;
         st_rp         <= '0;
         st_fill       <= '0;
         rd_cred       <= CRED;
         sif.rd_valid  <= 1'b0;
         sif.wr_credit <= 1'b0;
      end else begin
         sif.rd_valid  <= send;
         sif.wr_credit <= commit; // credit back per committed byte
         if (accept) begin
            state <= sif.req_write ? S_WR : S_RD;
            idx   <= '0;
         end else if (commit || send) begin
            idx <= idx + 1'b1;
            if (idx == LAST_IDX) state <= S_IDLE;
         end
         if (sif.wr_valid) st_wp <= st_wp + 1'b1;
         if (commit) st_rp <= st_rp + 1'b1;
         st_fill <= st_fill + fdc_credit_t'(sif.wr_valid) - fdc_credit_t'(commit);
         rd_cred <= rd_cred - fdc_credit_t'(send) + fdc_credit_t'(sif.rd_credit);
      end
   end

   always_ff @(posedge clk) begin
      if (accept) blk <= sif.req_block[AW-IW-1:0];
      if (sif.wr_valid) stage[st_wp] <= sif.wr_data;
      if (commit) mem[addr] <= stage[st_rp];
      if (send) sif.rd_data <= mem[addr];
   end

endmodule

// File: rtl/fdc.sv
/*
 * floppy controller top:
 * ISA I/O and DMA channel 2 pins,
 * registers, sector engine, block store
 */
`timescale 1ns/10ps

module fdc import fdc_pkg::*; (
   input  logic        clk,   // system clock
   input  logic        rst,   // sync reset
   input  logic [19:0] a,     // address
   input  fdc_byte_t   d_in,  // data from host
   input  logic        ior_n, // io read
   input  logic        iow_n, // io write
   input  logic        dack2, // dma acknowledge 2
   input  logic        tc,    // terminal count
   output fdc_byte_t   d_out, // data to host
   output logic        d_oe,  // drive d_out
   output logic        irq6,  // irq number 6
   output logic        drq2   // drq number 2
);

   logic        cmd_start;  // regs to engine
   logic        cmd_write;
   fdc_block_t  cmd_block;
   logic        dma_en;
   logic        cmd_busy;   // engine to regs
   logic        cmd_done;
   fdc_status_t cmd_status;
   fdc_byte_t   reg_d_out;  // register read source
   logic        reg_d_oe;
   fdc_byte_t   dma_d_out;  // dma read source
   logic        dma_d_oe;

   sector_if sif_i ();

   // dack2 keeps the two sources apart, each is zero when idle
   assign d_out = reg_d_out | dma_d_out;
   assign d_oe  = reg_d_oe | dma_d_oe;

   fdc_regs regs_i (
      .clk        (clk),
      .rst        (rst),
      .a          (a),
      .d_in       (d_in),
      .ior_n      (ior_n),
      .iow_n      (iow_n),
      .dack2      (dack2),
      .cmd_busy   (cmd_busy),
      .cmd_done   (cmd_done),
      .cmd_status (cmd_status),
      .reg_d_out  (reg_d_out),
      .reg_d_oe   (reg_d_oe),
      .irq6       (irq6),
      .cmd_start  (cmd_start),
      .cmd_write  (cmd_write),
      .cmd_block  (cmd_block),
      .dma_en     (dma_en)
   );

   sector_engine eng_i (
      .clk        (clk),
      .rst        (rst),
      .cmd_start  (cmd_start),
      .cmd_write  (cmd_write),
      .cmd_block  (cmd_block),
      .dma_en     (dma_en),
      .dack2      (dack2),
      .tc         (tc),
      .ior_n      (ior_n),
      .iow_n      (iow_n),
      .d_in       (d_in),
      .cmd_busy   (cmd_busy),
      .cmd_done   (cmd_done),
      .cmd_status (cmd_status),
      .drq2       (drq2),
      .dma_d_out  (dma_d_out),
      .dma_d_oe   (dma_d_oe),
      .sif        (sif_i.engine)
   );

   sd_block_store store_i (
      .clk (clk),
      .rst (rst),
      .sif (sif_i.store)
   );

endmodule

// File: test/tb_fdc.sv
/*
 * floppy controller testbench:
 * clock and reset, stimulus file replay, ISA I/O and DMA tasks,
 * shadow block data, result checks, cycle limit
 */
`timescale 1ns/10ps
`include "fdc_settings.svh"

module tb_fdc;

   localparam int          SB  = `FDC_SECTOR_BYTES;
   localparam int          REC = 5 + SB;            // op dor blk tcn exp and data words
   localparam logic [19:0] IO  = `FDC_IO_BASE;

   logic        clk;
   logic        rst;
   logic [19:0] a;
   logic [7:0]  d_in;
   logic        ior_n;
   logic        iow_n;
   logic        dack2;
   logic        tc;
   logic [7:0]  d_out;
   logic        d_oe;
   logic        irq6;
   logic        drq2;
   logic [7:0]  stim [0:1023];   // flat stimulus words
   logic [7:0]  shadow [16][SB]; // expected block contents
   int          errors = 0;
   int          cycles = 0;
   int          limit  = 100000; // replaced once the file is read
   int          nrec;

   fdc dut_i (.clk(clk), .rst(rst), .a(a), .d_in(d_in), .ior_n(ior_n), .iow_n(iow_n),
              .dack2(dack2), .tc(tc), .d_out(d_out), .d_oe(d_oe), .irq6(irq6), .drq2(drq2));

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk; // 8 ns period
   end

   always @(posedge clk) begin
      cycles = cycles + 1;
      if (cycles > limit) begin
         $display("Run stopped: cycle limit of %0d reached", limit);
         $display("Something failed");
         $finish;
      end
   end

   task automatic check(input logic [7:0] got, input logic [7:0] exp, input string msg);
      if (got !== exp) begin
         errors++;
         $display("Mismatch at %0d ns: %s, got %0h, expected %0h", $time, msg, got, exp);
      end
   endtask

   // all bus tasks start and end on a falling edge
   task automatic io_write(input logic [19:0] addr, input logic [7:0] val);
      a     = addr;
      d_in  = val;
      iow_n = 1'b0;
      @(negedge clk);
      iow_n = 1'b1;
      a     = '0;
   endtask

   task automatic io_read(input logic [19:0] addr, output logic [7:0] val, output logic oe);
      a     = addr;
      ior_n = 1'b0;
      #2;             // comb path settled
      val   = d_out;
      oe    = d_oe;
      @(negedge clk);
      ior_n = 1'b1;
      a     = '0;
   endtask

   task automatic dma_xfer(input int base, input logic wr, input int n, input int tcn);
      logic [3:0] blk;
      blk = stim[base+2][3:0];
      for (int i = 0; i < n; i++) begin
         while (!drq2) @(negedge clk); // host waits for the request
         dack2 = 1'b1;
         tc    = (i + 1 == tcn);       // early end on this byte
         if (wr) begin
            iow_n = 1'b0;
            d_in  = stim[base+5+i];
         end else begin
            ior_n = 1'b0;
         end
         #2;
         if (!wr) begin
            check(d_out, shadow[blk][i], "dma read byte");
            check({7'd0, d_oe}, 8'h01, "d_oe on dma read");
         end
         @(negedge clk);
         dack2 = 1'b0;
         ior_n = 1'b1;
         iow_n = 1'b1;
         tc    = 1'b0;
      end
   endtask

   task automatic wait_irq(output logic seen);
      int n;
      n = 0;
      while (!irq6 && n < 100) begin
         @(negedge clk);
         n++;
      end
      seen = irq6;
   endtask

   initial begin
      logic [7:0] rd;
      logic       oe;
      logic       irq_ok;
      int         base;
      int         n;
      a     = '0;
      d_in  = '0;
      ior_n = 1'b1;
      iow_n = 1'b1;
      dack2 = 1'b0;
      tc    = 1'b0;
      rst   = 1'b1;
      $readmemh("test/fdc_stimulus.txt", stim);
      nrec = 0;
      while (stim[nrec*REC] !== 8'hFF) nrec++; // FF ends the list
      limit = 200 * nrec + 500;
      repeat (5) @(negedge clk);
      rst = 1'b0;
      check({7'd0, irq6}, 8'h00, "irq6 after reset");
      check({7'd0, drq2}, 8'h00, "drq2 after reset");
      io_read(IO + 20'd4, rd, oe);
      check(rd & 8'h80, 8'h80, "msr ready bit after reset");
      io_write(IO + 20'd2, 8'h0C);
      io_read(IO + 20'd2, rd, oe);
      check(rd, 8'h0C, "dor readback");
      check({7'd0, oe}, 8'h01, "d_oe on register read");
      io_write(20'h3E2, 8'h55); // outside the window
      io_read(IO + 20'd2, rd, oe);
      check(rd, 8'h0C, "dor after out-of-range write");
      io_read(20'h3E2, rd, oe);
      check({7'd0, oe}, 8'h00, "d_oe on out-of-range read");
      for (int r = 0; r < nrec; r++) begin
         base = r * REC;
         n    = (stim[base+3] != 8'h00) ? int'(stim[base+3]) : SB;
         io_write(IO + 20'd2, stim[base+1]);
         io_write(IO + 20'd5, stim[base]);   // opcode
         io_write(IO + 20'd5, stim[base+2]); // block
         if (stim[base+4] != 8'h80) dma_xfer(base, stim[base] == 8'h05, n, int'(stim[base+3]));
         wait_irq(irq_ok);
         if (!irq_ok) begin
            errors++;
            $display("No interrupt at the end of command %0d", r);
         end
         io_read(IO + 20'd5, rd, oe);
         check(rd, stim[base+4], "result byte");
         check({7'd0, irq6}, 8'h00, "irq6 after result read");
         if (stim[base+4] == 8'h80) begin
            repeat (10) begin
               @(negedge clk);
               check({7'd0, drq2}, 8'h00, "drq2 on rejected command");
            end
         end
         if (stim[base] == 8'h05 && stim[base+4] == 8'h00) begin
            for (int i = 0; i < SB; i++) shadow[stim[base+2][3:0]][i] = stim[base+5+i];
         end
      end
      $display("Checks done, %0d error(s)", errors);
      if (errors == 0) begin
         $display("Everything OK");
      end else begin
         $display("Something failed");
      end
      $finish;
   end

endmodule

// File: test/fdc_stimulus.txt
// op dor blk tcn exp, then 16 data bytes (used by op 05 writes, zero for others)
// op 05 write, 06 read; tcn = byte that carries tc, 00 for none; exp = result byte
// write block 3, read it back
05 0C 03 00 00 11 22 33 44 55 66 77 88 99 AA BB CC DD EE F0 0F
06 0C 03 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
// two blocks, read back in reverse order
05 0C 07 00 00 A0 A1 A2 A3 A4 A5 A6 A7 A8 A9 AA AB AC AD AE AF
05 0C 09 00 00 5A 4B 3C 2D 1E 0F F1 E2 D3 C4 B5 A6 97 88 79 6A
06 0C 09 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
06 0C 07 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
// write cut by tc on byte 8, then a full write and read
05 0C 0A 08 40 C3 3C 96 69 E1 1E D2 2D 00 00 00 00 00 00 00 00
05 0C 0A 00 00 01 02 04 08 10 20 40 80 FE FD FB F7 EF DF BF 7F
06 0C 0A 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
// dma off in dor, then an unknown opcode
05 04 05 00 80 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
11 0C 05 00 80 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
FF

// File: compile.f
+incdir+common
common/fdc_pkg.sv
common/sector_if.sv
floppy/fdc_regs.sv
floppy/sector_engine.sv
sdcard/sd_block_store.sv
rtl/fdc.sv
test/tb_fdc.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the floppy controller testbench with Verilator
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module tb_fdc -f compile.f -o sim_fdc

./obj_dir/sim_fdc | tee sim.log

if grep -q "Something failed" sim.log; then
   echo "simulation reported a failure, see sim.log"
   exit 1
fi
echo "simulation finished without failures"
